//--- rtl/xcvr_csr_pkg.sv
`default_nettype none

package xcvr_csr_pkg;

  // counter geometry, seven bytes per 50-bit count
  localparam int PRBS_COUNT_W = 50;
  localparam int PRBS_BYTES   = 7;
  localparam int PRBS_PAD_W   = PRBS_BYTES * 8 - PRBS_COUNT_W;

  // status and error-clear synchronizer depth
  localparam int SYNC_STAGES  = 3;

  // bus widths
  typedef logic [8:0]              csr_addr_t;
  typedef logic [7:0]              csr_data_t;
  typedef logic [PRBS_COUNT_W-1:0] prbs_count_t;

  // unmapped reads
  localparam csr_data_t RD_UNUSED = 8'h00;

  // register map
  localparam csr_addr_t ADDR_GP_RD_LTR     = 9'h080;
  localparam csr_addr_t ADDR_GP_CAL_BUSY   = 9'h081;
  localparam csr_addr_t ADDR_GP_SET_LTR    = 9'h082;
  localparam csr_addr_t ADDR_GP_LPBK       = 9'h083;
  localparam csr_addr_t ADDR_CHNL_RESET    = 9'h084;
  localparam csr_addr_t ADDR_PRBS_CTRL     = 9'h100;
  // both counter windows are lsb byte first
  localparam csr_addr_t ADDR_PRBS_ERR_BASE = 9'h101;
  localparam csr_addr_t ADDR_PRBS_BIT_BASE = 9'h108;

  // lock status byte
  localparam int OFFSET_RD_LTR      = 0;
  localparam int OFFSET_RD_LTD      = 1;

  // cal busy byte, bit 3 reads zero
  localparam int OFFSET_TX_CAL_BUSY = 0;
  localparam int OFFSET_RX_CAL_BUSY = 1;
  localparam int OFFSET_AVMM_BUSY   = 2;
  localparam int OFFSET_TX_CAL_MASK = 4;
  localparam int OFFSET_RX_CAL_MASK = 5;

  // set lock byte
  localparam int OFFSET_SET_LTR     = 0;
  localparam int OFFSET_SET_LTD     = 1;
  localparam int OFFSET_SET_LTR_OVR = 2;
  localparam int OFFSET_SET_LTD_OVR = 3;

  // loopback byte
  localparam int OFFSET_LPBK        = 0;

  // channel reset byte, values low nibble, overrides high nibble
  localparam int OFFSET_RX_ANA      = 0;
  localparam int OFFSET_RX_DIG      = 1;
  localparam int OFFSET_TX_ANA      = 2;
  localparam int OFFSET_TX_DIG      = 3;
  localparam int OFFSET_RX_ANA_OVR  = 4;
  localparam int OFFSET_RX_DIG_OVR  = 5;
  localparam int OFFSET_TX_ANA_OVR  = 6;
  localparam int OFFSET_TX_DIG_OVR  = 7;

  // prbs control byte
  localparam int OFFSET_PRBS_EN     = 0;
  localparam int OFFSET_PRBS_RESET  = 1;
  localparam int OFFSET_PRBS_SNAP   = 2;
  localparam int OFFSET_PRBS_DONE   = 3;

  // write byte plus one strobe per writable register
  typedef struct packed {
    csr_data_t data;
    logic      wr_cal_busy;
    logic      wr_set_ltr;
    logic      wr_lpbk;
    logic      wr_chnl_reset;
    logic      wr_prbs_ctrl;
  } csr_wr_t;

  // channel controls, user side in and channel side out
  typedef struct packed {
    logic lock_to_ref;
    logic lock_to_data;
    logic loopback;
    logic rx_analogreset;
    logic rx_digitalreset;
    logic tx_analogreset;
    logic tx_digitalreset;
  } chan_ctrl_t;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_DATA = 1'b1
  } rd_state_t;

endpackage

`default_nettype wire

//--- rtl/xcvr_csr_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_csr_bus_ctrl (
  input  wire                         avmm_clk,
  input  wire                         avmm_reset,
  input  wire xcvr_csr_pkg::csr_addr_t   address,
  input  wire xcvr_csr_pkg::csr_data_t   writedata,
  input  wire                         write,
  input  wire                         read,
  output xcvr_csr_pkg::csr_data_t     readdata,
  output logic                        waitrequest,
  output xcvr_csr_pkg::csr_wr_t       wr,
  input  wire xcvr_csr_pkg::csr_data_t   rd_ltr_status,
  input  wire xcvr_csr_pkg::csr_data_t   rd_cal_busy,
  input  wire xcvr_csr_pkg::csr_data_t   rd_set_ltr,
  input  wire xcvr_csr_pkg::csr_data_t   rd_loopback,
  input  wire xcvr_csr_pkg::csr_data_t   rd_chnl_reset,
  input  wire xcvr_csr_pkg::csr_data_t   rd_prbs_ctrl,
  input  wire xcvr_csr_pkg::prbs_count_t prbs_err,
  input  wire xcvr_csr_pkg::prbs_count_t prbs_bit
);

  xcvr_csr_pkg::rd_state_t rd_state;
  xcvr_csr_pkg::rd_state_t rd_state_nxt;
  xcvr_csr_pkg::csr_data_t rd_byte;
  // counters split into bytes, top byte zero padded above bit 49
  xcvr_csr_pkg::csr_data_t [xcvr_csr_pkg::PRBS_BYTES-1:0] err_bytes;
  xcvr_csr_pkg::csr_data_t [xcvr_csr_pkg::PRBS_BYTES-1:0] bit_bytes;
  // offsets into the counter windows, wrap high below the base
  xcvr_csr_pkg::csr_addr_t err_off;
  xcvr_csr_pkg::csr_addr_t bit_off;

  // one wait cycle per read, only while the host reads
  assign waitrequest = read && (rd_state == xcvr_csr_pkg::RD_IDLE);

  always_comb begin
    case (rd_state)
      xcvr_csr_pkg::RD_IDLE: begin
        rd_state_nxt = read ? xcvr_csr_pkg::RD_DATA : xcvr_csr_pkg::RD_IDLE;
      end
      // data cycle always ends the read
      default: begin
        rd_state_nxt = xcvr_csr_pkg::RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      rd_state <= xcvr_csr_pkg::RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  // byte captured on the wait edge, valid in RD_DATA
  always_ff @(posedge avmm_clk) begin
    if (waitrequest) begin
      readdata <= rd_byte;
    end
  end

  // write strobes, zero wait states
  always_comb begin
    wr               = '0;
    wr.data          = writedata;
    wr.wr_cal_busy   = write && (address == xcvr_csr_pkg::ADDR_GP_CAL_BUSY);
    wr.wr_set_ltr    = write && (address == xcvr_csr_pkg::ADDR_GP_SET_LTR);
    wr.wr_lpbk       = write && (address == xcvr_csr_pkg::ADDR_GP_LPBK);
    wr.wr_chnl_reset = write && (address == xcvr_csr_pkg::ADDR_CHNL_RESET);
    wr.wr_prbs_ctrl  = write && (address == xcvr_csr_pkg::ADDR_PRBS_CTRL);
  end

  assign err_bytes = {{xcvr_csr_pkg::PRBS_PAD_W{1'b0}}, prbs_err};
  assign bit_bytes = {{xcvr_csr_pkg::PRBS_PAD_W{1'b0}}, prbs_bit};
  assign err_off   = address - xcvr_csr_pkg::ADDR_PRBS_ERR_BASE;
  assign bit_off   = address - xcvr_csr_pkg::ADDR_PRBS_BIT_BASE;

  // readdata mux
  always_comb begin
    rd_byte = xcvr_csr_pkg::RD_UNUSED;
    case (address)
      xcvr_csr_pkg::ADDR_GP_RD_LTR:   rd_byte = rd_ltr_status;
      xcvr_csr_pkg::ADDR_GP_CAL_BUSY: rd_byte = rd_cal_busy;
      xcvr_csr_pkg::ADDR_GP_SET_LTR:  rd_byte = rd_set_ltr;
      xcvr_csr_pkg::ADDR_GP_LPBK:     rd_byte = rd_loopback;
      xcvr_csr_pkg::ADDR_CHNL_RESET:  rd_byte = rd_chnl_reset;
      xcvr_csr_pkg::ADDR_PRBS_CTRL:   rd_byte = rd_prbs_ctrl;
      default: begin
        // counter windows, 0x101-0x107 errors and 0x108-0x10e bits
        if (err_off < xcvr_csr_pkg::csr_addr_t'(xcvr_csr_pkg::PRBS_BYTES)) begin
          rd_byte = err_bytes[err_off[2:0]];
        end else if (bit_off < xcvr_csr_pkg::csr_addr_t'(xcvr_csr_pkg::PRBS_BYTES)) begin
          rd_byte = bit_bytes[bit_off[2:0]];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/xcvr_status_sync.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_status_sync (
  input  wire                     avmm_clk,
  input  wire                     avmm_reset,
  input  wire xcvr_csr_pkg::csr_wr_t wr,
  input  wire                     rx_is_lockedtodata,
  input  wire                     rx_is_lockedtoref,
  input  wire                     tx_cal_busy,
  input  wire                     rx_cal_busy,
  input  wire                     avmm_busy,
  output logic                    tx_cal_busy_mask,
  output logic                    rx_cal_busy_mask,
  output xcvr_csr_pkg::csr_data_t rd_ltr_status,
  output xcvr_csr_pkg::csr_data_t rd_cal_busy
);

  // one 4-bit word per stage, last stage is the synchronized value
  logic [xcvr_csr_pkg::SYNC_STAGES-1:0][3:0] status_sync;
  logic ltr_s;
  logic ltd_s;
  logic tx_busy_s;
  logic rx_busy_s;
  logic avmm_busy_q;

  // async channel status into the avmm domain
  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      status_sync <= '0;
    end else begin
      status_sync <= {status_sync[xcvr_csr_pkg::SYNC_STAGES-2:0],
                      {rx_cal_busy, tx_cal_busy, rx_is_lockedtodata, rx_is_lockedtoref}};
    end
  end

  assign {rx_busy_s, tx_busy_s, ltd_s, ltr_s} = status_sync[xcvr_csr_pkg::SYNC_STAGES-1];

  // avmm_busy is already in this domain, one flop only
  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      avmm_busy_q <= 1'b0;
    end else begin
      avmm_busy_q <= avmm_busy;
    end
  end

  // masks come out of reset set
  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      tx_cal_busy_mask <= 1'b1;
      rx_cal_busy_mask <= 1'b1;
    end else if (wr.wr_cal_busy) begin
      tx_cal_busy_mask <= wr.data[xcvr_csr_pkg::OFFSET_TX_CAL_MASK];
      rx_cal_busy_mask <= wr.data[xcvr_csr_pkg::OFFSET_RX_CAL_MASK];
    end
  end

  // readback bytes, spare bits zero
  always_comb begin
    rd_ltr_status = xcvr_csr_pkg::RD_UNUSED;
    rd_ltr_status[xcvr_csr_pkg::OFFSET_RD_LTR] = ltr_s;
    rd_ltr_status[xcvr_csr_pkg::OFFSET_RD_LTD] = ltd_s;

    rd_cal_busy = xcvr_csr_pkg::RD_UNUSED;
    rd_cal_busy[xcvr_csr_pkg::OFFSET_TX_CAL_BUSY] = tx_busy_s;
    rd_cal_busy[xcvr_csr_pkg::OFFSET_RX_CAL_BUSY] = rx_busy_s;
    rd_cal_busy[xcvr_csr_pkg::OFFSET_AVMM_BUSY]   = avmm_busy_q;
    rd_cal_busy[xcvr_csr_pkg::OFFSET_TX_CAL_MASK] = tx_cal_busy_mask;
    rd_cal_busy[xcvr_csr_pkg::OFFSET_RX_CAL_MASK] = rx_cal_busy_mask;
  end

endmodule

`default_nettype wire

//--- rtl/xcvr_chan_override.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_chan_override (
  input  wire                        avmm_clk,
  input  wire                        avmm_reset,
  input  wire xcvr_csr_pkg::csr_wr_t    wr,
  input  wire xcvr_csr_pkg::chan_ctrl_t chan_ctrl_in,
  output xcvr_csr_pkg::chan_ctrl_t   chan_ctrl_out,
  output xcvr_csr_pkg::csr_data_t    rd_set_ltr,
  output xcvr_csr_pkg::csr_data_t    rd_loopback,
  output xcvr_csr_pkg::csr_data_t    rd_chnl_reset
);

  // set lock register
  logic set_ltr_q;
  logic set_ltd_q;
  logic ltr_ovr_q;
  logic ltd_ovr_q;
  // loopback register
  logic lpbk_q;
  // channel reset register, every bit is defined so the byte is kept whole
  xcvr_csr_pkg::csr_data_t rst_q;

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      set_ltr_q <= 1'b0;
      set_ltd_q <= 1'b0;
      ltr_ovr_q <= 1'b0;
      ltd_ovr_q <= 1'b0;
      lpbk_q    <= 1'b0;
      rst_q     <= '0;
    end else begin
      if (wr.wr_set_ltr) begin
        set_ltr_q <= wr.data[xcvr_csr_pkg::OFFSET_SET_LTR];
        set_ltd_q <= wr.data[xcvr_csr_pkg::OFFSET_SET_LTD];
        ltr_ovr_q <= wr.data[xcvr_csr_pkg::OFFSET_SET_LTR_OVR];
        ltd_ovr_q <= wr.data[xcvr_csr_pkg::OFFSET_SET_LTD_OVR];
      end
      if (wr.wr_lpbk) begin
        lpbk_q <= wr.data[xcvr_csr_pkg::OFFSET_LPBK];
      end
      if (wr.wr_chnl_reset) begin
        rst_q <= wr.data;
      end
    end
  end

  // override muxes, user input passes unless the override bit is set
  always_comb begin
    chan_ctrl_out.lock_to_ref  = ltr_ovr_q ? set_ltr_q : chan_ctrl_in.lock_to_ref;
    chan_ctrl_out.lock_to_data = ltd_ovr_q ? set_ltd_q : chan_ctrl_in.lock_to_data;

    // loopback has no override, either side can enable it
    chan_ctrl_out.loopback = lpbk_q || chan_ctrl_in.loopback;

    chan_ctrl_out.rx_analogreset  = rst_q[xcvr_csr_pkg::OFFSET_RX_ANA_OVR] ?
                                    rst_q[xcvr_csr_pkg::OFFSET_RX_ANA] :
                                    chan_ctrl_in.rx_analogreset;
    chan_ctrl_out.rx_digitalreset = rst_q[xcvr_csr_pkg::OFFSET_RX_DIG_OVR] ?
                                    rst_q[xcvr_csr_pkg::OFFSET_RX_DIG] :
                                    chan_ctrl_in.rx_digitalreset;
    chan_ctrl_out.tx_analogreset  = rst_q[xcvr_csr_pkg::OFFSET_TX_ANA_OVR] ?
                                    rst_q[xcvr_csr_pkg::OFFSET_TX_ANA] :
                                    chan_ctrl_in.tx_analogreset;
    chan_ctrl_out.tx_digitalreset = rst_q[xcvr_csr_pkg::OFFSET_TX_DIG_OVR] ?
                                    rst_q[xcvr_csr_pkg::OFFSET_TX_DIG] :
                                    chan_ctrl_in.tx_digitalreset;
  end

  // readback bytes
  always_comb begin
    rd_set_ltr = xcvr_csr_pkg::RD_UNUSED;
    rd_set_ltr[xcvr_csr_pkg::OFFSET_SET_LTR]     = set_ltr_q;
    rd_set_ltr[xcvr_csr_pkg::OFFSET_SET_LTD]     = set_ltd_q;
    rd_set_ltr[xcvr_csr_pkg::OFFSET_SET_LTR_OVR] = ltr_ovr_q;
    rd_set_ltr[xcvr_csr_pkg::OFFSET_SET_LTD_OVR] = ltd_ovr_q;

    rd_loopback = xcvr_csr_pkg::RD_UNUSED;
    rd_loopback[xcvr_csr_pkg::OFFSET_LPBK] = lpbk_q;

    rd_chnl_reset = rst_q;
  end

endmodule

`default_nettype wire

//--- rtl/xcvr_prbs_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_prbs_ctrl (
  input  wire                     avmm_clk,
  input  wire                     avmm_reset,
  input  wire xcvr_csr_pkg::csr_wr_t wr,
  input  wire                     rx_prbs_err_clr,
  input  wire                     prbs_done,
  output logic                    prbs_count_en,
  output logic                    prbs_snap,
  output logic                    prbs_reset,
  output xcvr_csr_pkg::csr_data_t rd_prbs_ctrl
);

  logic prbs_en_q;
  logic prbs_rst_q;
  logic prbs_snap_q;
  // error clear comes from the rx side
  logic [xcvr_csr_pkg::SYNC_STAGES-1:0] clr_sync;

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      prbs_en_q   <= 1'b0;
      prbs_rst_q  <= 1'b0;
      prbs_snap_q <= 1'b0;
    end else if (wr.wr_prbs_ctrl) begin
      prbs_en_q   <= wr.data[xcvr_csr_pkg::OFFSET_PRBS_EN];
      prbs_rst_q  <= wr.data[xcvr_csr_pkg::OFFSET_PRBS_RESET];
      prbs_snap_q <= wr.data[xcvr_csr_pkg::OFFSET_PRBS_SNAP];
    end
  end

  always_ff @(posedge avmm_clk or posedge avmm_reset) begin
    if (avmm_reset) begin
      clr_sync <= '0;
    end else begin
      clr_sync <= {clr_sync[xcvr_csr_pkg::SYNC_STAGES-2:0], rx_prbs_err_clr};
    end
  end

  // accumulator controls
  assign prbs_count_en = prbs_en_q;
  assign prbs_snap     = prbs_snap_q;
  // either the register or a user clear resets the counters
  assign prbs_reset    = prbs_rst_q || clr_sync[xcvr_csr_pkg::SYNC_STAGES-1];

  // readback, done is live from the accumulator
  always_comb begin
    rd_prbs_ctrl = xcvr_csr_pkg::RD_UNUSED;
    rd_prbs_ctrl[xcvr_csr_pkg::OFFSET_PRBS_EN]    = prbs_en_q;
    rd_prbs_ctrl[xcvr_csr_pkg::OFFSET_PRBS_RESET] = prbs_rst_q;
    rd_prbs_ctrl[xcvr_csr_pkg::OFFSET_PRBS_SNAP]  = prbs_snap_q;
    rd_prbs_ctrl[xcvr_csr_pkg::OFFSET_PRBS_DONE]  = prbs_done;
  end

endmodule

`default_nettype wire

//--- rtl/xcvr_debug_csr.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_debug_csr (
  input  wire                           avmm_clk,
  input  wire                           avmm_reset,
  input  wire xcvr_csr_pkg::csr_addr_t     avmm_address,
  input  wire xcvr_csr_pkg::csr_data_t     avmm_writedata,
  input  wire                           avmm_write,
  input  wire                           avmm_read,
  output xcvr_csr_pkg::csr_data_t       avmm_readdata,
  output logic                          avmm_waitrequest,
  // prbs accumulator
  input  wire xcvr_csr_pkg::prbs_count_t   prbs_err,
  input  wire xcvr_csr_pkg::prbs_count_t   prbs_bit,
  input  wire                           prbs_done,
  output logic                          prbs_count_en,
  output logic                          prbs_snap,
  output logic                          prbs_reset,
  // channel status
  input  wire                           rx_is_lockedtodata,
  input  wire                           rx_is_lockedtoref,
  input  wire                           tx_cal_busy,
  input  wire                           rx_cal_busy,
  input  wire                           avmm_busy,
  input  wire                           rx_prbs_err_clr,
  // channel controls
  input  wire xcvr_csr_pkg::chan_ctrl_t    chan_ctrl_in,
  output xcvr_csr_pkg::chan_ctrl_t      chan_ctrl_out,
  output logic                          csr_tx_cal_busy_mask,
  output logic                          csr_rx_cal_busy_mask
);

  xcvr_csr_pkg::csr_wr_t   wr;
  xcvr_csr_pkg::csr_data_t rd_ltr_status;
  xcvr_csr_pkg::csr_data_t rd_cal_busy;
  xcvr_csr_pkg::csr_data_t rd_set_ltr;
  xcvr_csr_pkg::csr_data_t rd_loopback;
  xcvr_csr_pkg::csr_data_t rd_chnl_reset;
  xcvr_csr_pkg::csr_data_t rd_prbs_ctrl;

  // address decode and readdata live here only
  xcvr_csr_bus_ctrl u_bus_ctrl (
    .avmm_clk      (avmm_clk),
    .avmm_reset    (avmm_reset),
    .address       (avmm_address),
    .writedata     (avmm_writedata),
    .write         (avmm_write),
    .read          (avmm_read),
    .readdata      (avmm_readdata),
    .waitrequest   (avmm_waitrequest),
    .wr            (wr),
    .rd_ltr_status (rd_ltr_status),
    .rd_cal_busy   (rd_cal_busy),
    .rd_set_ltr    (rd_set_ltr),
    .rd_loopback   (rd_loopback),
    .rd_chnl_reset (rd_chnl_reset),
    .rd_prbs_ctrl  (rd_prbs_ctrl),
    .prbs_err      (prbs_err),
    .prbs_bit      (prbs_bit)
  );

  xcvr_status_sync u_status_sync (
    .avmm_clk           (avmm_clk),
    .avmm_reset         (avmm_reset),
    .wr                 (wr),
    .rx_is_lockedtodata (rx_is_lockedtodata),
    .rx_is_lockedtoref  (rx_is_lockedtoref),
    .tx_cal_busy        (tx_cal_busy),
    .rx_cal_busy        (rx_cal_busy),
    .avmm_busy          (avmm_busy),
    .tx_cal_busy_mask   (csr_tx_cal_busy_mask),
    .rx_cal_busy_mask   (csr_rx_cal_busy_mask),
    .rd_ltr_status      (rd_ltr_status),
    .rd_cal_busy        (rd_cal_busy)
  );

  xcvr_chan_override u_chan_override (
    .avmm_clk      (avmm_clk),
    .avmm_reset    (avmm_reset),
    .wr            (wr),
    .chan_ctrl_in  (chan_ctrl_in),
    .chan_ctrl_out (chan_ctrl_out),
    .rd_set_ltr    (rd_set_ltr),
    .rd_loopback   (rd_loopback),
    .rd_chnl_reset (rd_chnl_reset)
  );

  xcvr_prbs_ctrl u_prbs_ctrl (
    .avmm_clk        (avmm_clk),
    .avmm_reset      (avmm_reset),
    .wr              (wr),
    .rx_prbs_err_clr (rx_prbs_err_clr),
    .prbs_done       (prbs_done),
    .prbs_count_en   (prbs_count_en),
    .prbs_snap       (prbs_snap),
    .prbs_reset      (prbs_reset),
    .rd_prbs_ctrl    (rd_prbs_ctrl)
  );

endmodule

`default_nettype wire

//--- tb/xcvr_debug_csr_assert.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_debug_csr_sva (
  input wire                           avmm_clk,
  input wire                           avmm_reset,
  input wire                           avmm_read,
  input wire                           avmm_waitrequest,
  input wire xcvr_csr_pkg::chan_ctrl_t chan_ctrl_in,
  input wire xcvr_csr_pkg::chan_ctrl_t chan_ctrl_out
);

  // a wait state only ever answers a read
  a_wait_needs_read: assert property (
    @(posedge avmm_clk) disable iff (avmm_reset)
    avmm_waitrequest |-> avmm_read
  ) else $error("waitrequest high while read is low");

  // one wait state per read, never two in a row
  a_wait_one_cycle: assert property (
    @(posedge avmm_clk) disable iff (avmm_reset)
    avmm_waitrequest |=> !avmm_waitrequest
  ) else $error("waitrequest high on two consecutive cycles");

  // user loopback can't be masked by the register
  a_lpbk_passes: assert property (
    @(posedge avmm_clk) disable iff (avmm_reset)
    chan_ctrl_in.loopback |-> chan_ctrl_out.loopback
  ) else $error("loopback input high but loopback output low");

endmodule

bind xcvr_debug_csr xcvr_debug_csr_sva xcvr_debug_csr_sva_inst (
  .avmm_clk         (avmm_clk),
  .avmm_reset       (avmm_reset),
  .avmm_read        (avmm_read),
  .avmm_waitrequest (avmm_waitrequest),
  .chan_ctrl_in     (chan_ctrl_in),
  .chan_ctrl_out    (chan_ctrl_out)
);

`default_nettype wire

//--- tb/xcvr_debug_csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xcvr_debug_csr_tb;

  // reads that see waitrequest longer than this are hung
  localparam int RD_TIMEOUT = 16;
  // reads or cycles allowed for a synchronized value to show up
  localparam int POLL_LIMIT = 12;

  // everything the testbench drives besides the bus
  typedef struct packed {
    logic                      ltr;
    logic                      ltd;
    logic                      tx_busy;
    logic                      rx_busy;
    logic                      avmm_busy;
    logic                      done;
    logic                      err_clr;
    xcvr_csr_pkg::chan_ctrl_t  chan_in;
    xcvr_csr_pkg::prbs_count_t err;
    xcvr_csr_pkg::prbs_count_t bits;
  } dut_in_t;

  // last byte written to each register
  typedef struct packed {
    xcvr_csr_pkg::csr_data_t cal;
    xcvr_csr_pkg::csr_data_t set_ltr;
    xcvr_csr_pkg::csr_data_t lpbk;
    xcvr_csr_pkg::csr_data_t rst;
    xcvr_csr_pkg::csr_data_t prbs;
  } shadow_t;

  logic                     avmm_clk;
  logic                     avmm_reset;
  xcvr_csr_pkg::csr_addr_t  avmm_address;
  xcvr_csr_pkg::csr_data_t  avmm_writedata;
  logic                     avmm_write;
  logic                     avmm_read;
  xcvr_csr_pkg::csr_data_t  avmm_readdata;
  logic                     avmm_waitrequest;
  logic                     prbs_count_en;
  logic                     prbs_snap;
  logic                     prbs_reset;
  xcvr_csr_pkg::chan_ctrl_t chan_ctrl_out;
  logic                     tx_mask;
  logic                     rx_mask;
  dut_in_t                  cur_in;
  shadow_t                  sh;
  integer                   seed;
  // pending comparisons, drained by the compare process
  string                    name_q[$];
  logic [7:0]               exp_q[$];
  logic [7:0]               act_q[$];

  xcvr_debug_csr xcvr_debug_csr_inst (
    .avmm_clk             (avmm_clk),
    .avmm_reset           (avmm_reset),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_write           (avmm_write),
    .avmm_read            (avmm_read),
    .avmm_readdata        (avmm_readdata),
    .avmm_waitrequest     (avmm_waitrequest),
    .prbs_err             (cur_in.err),
    .prbs_bit             (cur_in.bits),
    .prbs_done            (cur_in.done),
    .prbs_count_en        (prbs_count_en),
    .prbs_snap            (prbs_snap),
    .prbs_reset           (prbs_reset),
    .rx_is_lockedtodata   (cur_in.ltd),
    .rx_is_lockedtoref    (cur_in.ltr),
    .tx_cal_busy          (cur_in.tx_busy),
    .rx_cal_busy          (cur_in.rx_busy),
    .avmm_busy            (cur_in.avmm_busy),
    .rx_prbs_err_clr      (cur_in.err_clr),
    .chan_ctrl_in         (cur_in.chan_in),
    .chan_ctrl_out        (chan_ctrl_out),
    .csr_tx_cal_busy_mask (tx_mask),
    .csr_rx_cal_busy_mask (rx_mask)
  );

  // 8 ns clock
  initial begin
    avmm_clk = 1'b0;
    forever #4 avmm_clk = ~avmm_clk;
  end

  // expected readback byte and channel controls from the register map rules
  function automatic void ref_model(input xcvr_csr_pkg::csr_addr_t addr, input shadow_t s,
                                    input dut_in_t in,
                                    output xcvr_csr_pkg::csr_data_t exp_byte,
                                    output xcvr_csr_pkg::chan_ctrl_t exp_ctrl);
    logic [55:0] err_w;
    logic [55:0] bit_w;
    int          idx;
    err_w    = {6'd0, in.err};
    bit_w    = {6'd0, in.bits};
    exp_byte = 8'h00;
    case (addr)
      xcvr_csr_pkg::ADDR_GP_RD_LTR:   exp_byte = {6'd0, in.ltd, in.ltr};
      xcvr_csr_pkg::ADDR_GP_CAL_BUSY: begin
        exp_byte = {2'b00, s.cal[5:4], 1'b0, in.avmm_busy, in.rx_busy, in.tx_busy};
      end
      xcvr_csr_pkg::ADDR_GP_SET_LTR:  exp_byte = {4'd0, s.set_ltr[3:0]};
      xcvr_csr_pkg::ADDR_GP_LPBK:     exp_byte = {7'd0, s.lpbk[0]};
      xcvr_csr_pkg::ADDR_CHNL_RESET:  exp_byte = s.rst;
      xcvr_csr_pkg::ADDR_PRBS_CTRL:   exp_byte = {4'd0, in.done, s.prbs[2:0]};
      default: begin
        // 0x101 upward, seven error bytes then seven bit-count bytes
        idx = int'(addr) - 'h101;
        if (idx >= 0 && idx < 7) begin
          exp_byte = err_w[idx*8 +: 8];
        end else if (idx >= 7 && idx < 14) begin
          exp_byte = bit_w[(idx-7)*8 +: 8];
        end
      end
    endcase
    // register bit wins only where its override is set
    exp_ctrl.lock_to_ref     = s.set_ltr[2] ? s.set_ltr[0] : in.chan_in.lock_to_ref;
    exp_ctrl.lock_to_data    = s.set_ltr[3] ? s.set_ltr[1] : in.chan_in.lock_to_data;
    exp_ctrl.loopback        = s.lpbk[0] | in.chan_in.loopback;
    exp_ctrl.rx_analogreset  = s.rst[4] ? s.rst[0] : in.chan_in.rx_analogreset;
    exp_ctrl.rx_digitalreset = s.rst[5] ? s.rst[1] : in.chan_in.rx_digitalreset;
    exp_ctrl.tx_analogreset  = s.rst[6] ? s.rst[2] : in.chan_in.tx_analogreset;
    exp_ctrl.tx_digitalreset = s.rst[7] ? s.rst[3] : in.chan_in.tx_digitalreset;
  endfunction

  task automatic post_check(input string name, input logic [7:0] exp, input logic [7:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic fail_plain(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  // compares everything queued since the last falling edge
  always @(negedge avmm_clk) begin : compare_proc
    string      nm;
    logic [7:0] e;
    logic [7:0] a;
    while (act_q.size() > 0) begin
      nm = name_q.pop_front();
      e  = exp_q.pop_front();
      a  = act_q.pop_front();
      assert (a === e) else begin
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, nm, e, a);
        $display("Testbench failed");
        $fatal(1, "first mismatch stops the run");
      end
    end
  end

  // zero wait state write, the shadow follows the register
  task automatic bus_write(input xcvr_csr_pkg::csr_addr_t addr,
                           input xcvr_csr_pkg::csr_data_t data);
    @(negedge avmm_clk);
    avmm_write     = 1'b1;
    avmm_address   = addr;
    avmm_writedata = data;
    @(negedge avmm_clk);
    avmm_write = 1'b0;
    case (addr)
      xcvr_csr_pkg::ADDR_GP_CAL_BUSY: sh.cal     = data;
      xcvr_csr_pkg::ADDR_GP_SET_LTR:  sh.set_ltr = data;
      xcvr_csr_pkg::ADDR_GP_LPBK:     sh.lpbk    = data;
      xcvr_csr_pkg::ADDR_CHNL_RESET:  sh.rst     = data;
      xcvr_csr_pkg::ADDR_PRBS_CTRL:   sh.prbs    = data;
      default: ;
    endcase
  endtask

  // read held until waitrequest drops, sampled 1 ns after each falling edge
  task automatic bus_read(input xcvr_csr_pkg::csr_addr_t addr,
                          output xcvr_csr_pkg::csr_data_t data);
    int waits;
    @(negedge avmm_clk);
    avmm_read    = 1'b1;
    avmm_address = addr;
    waits        = 0;
    #1;
    while (avmm_waitrequest) begin
      waits++;
      if (waits > RD_TIMEOUT) begin
        fail_plain($sformatf("read of address %h never saw waitrequest go low", addr));
      end
      @(negedge avmm_clk);
      #1;
    end
    data = avmm_readdata;
    // exactly one wait state per read
    post_check("avmm_waitrequest cycles", 8'd1, waits[7:0]);
    @(negedge avmm_clk);
    avmm_read = 1'b0;
  endtask

  task automatic check_read(input xcvr_csr_pkg::csr_addr_t addr);
    xcvr_csr_pkg::csr_data_t  rd;
    xcvr_csr_pkg::csr_data_t  eb;
    xcvr_csr_pkg::chan_ctrl_t ec;
    bus_read(addr, rd);
    ref_model(addr, sh, cur_in, eb, ec);
    post_check($sformatf("avmm_readdata[%h]", addr), eb, rd);
  endtask

  // outputs that follow registers, no clear pulse in flight
  task automatic check_outputs();
    xcvr_csr_pkg::csr_data_t  eb;
    xcvr_csr_pkg::chan_ctrl_t ec;
    #1;
    ref_model(xcvr_csr_pkg::ADDR_PRBS_CTRL, sh, cur_in, eb, ec);
    post_check("chan_ctrl_out", {1'b0, ec}, {1'b0, chan_ctrl_out});
    post_check("csr_tx_cal_busy_mask", {7'd0, sh.cal[4]}, {7'd0, tx_mask});
    post_check("csr_rx_cal_busy_mask", {7'd0, sh.cal[5]}, {7'd0, rx_mask});
    post_check("prbs_count_en", {7'd0, sh.prbs[0]}, {7'd0, prbs_count_en});
    post_check("prbs_reset", {7'd0, sh.prbs[1]}, {7'd0, prbs_reset});
    post_check("prbs_snap", {7'd0, sh.prbs[2]}, {7'd0, prbs_snap});
  endtask

  // re-read a status byte until the synchronizers catch up
  task automatic poll_status(input xcvr_csr_pkg::csr_addr_t addr);
    xcvr_csr_pkg::csr_data_t  rd;
    xcvr_csr_pkg::csr_data_t  eb;
    xcvr_csr_pkg::chan_ctrl_t ec;
    int                       tries;
    ref_model(addr, sh, cur_in, eb, ec);
    rd    = ~eb;
    tries = 0;
    while (rd !== eb && tries < POLL_LIMIT) begin
      bus_read(addr, rd);
      tries++;
    end
    if (rd !== eb) begin
      fail_plain($sformatf("status byte at address %h never reached its expected value", addr));
    end
  endtask

  initial begin : stimulus
    xcvr_csr_pkg::csr_addr_t unmapped [6];
    xcvr_csr_pkg::csr_addr_t wr_addrs [5];
    logic [31:0]             r32;
    logic [63:0]             r64;
    logic                    seen;
    int                      k;
    int                      guard;
    seed           = 45;
    avmm_reset     = 1'b1;
    avmm_address   = '0;
    avmm_writedata = '0;
    avmm_write     = 1'b0;
    avmm_read      = 1'b0;
    cur_in         = '0;
    r32            = $random(seed);
    cur_in.chan_in = r32[6:0];
    // masks come out of reset set
    sh             = '0;
    sh.cal         = 8'h30;
    unmapped = '{9'h000, 9'h07f, 9'h085, 9'h0ff, 9'h10f, 9'h1ff};
    wr_addrs = '{xcvr_csr_pkg::ADDR_GP_SET_LTR, xcvr_csr_pkg::ADDR_GP_LPBK,
                 xcvr_csr_pkg::ADDR_CHNL_RESET, xcvr_csr_pkg::ADDR_GP_CAL_BUSY,
                 xcvr_csr_pkg::ADDR_PRBS_CTRL};
    repeat (8) @(negedge avmm_clk);
    avmm_reset = 1'b0;

    // reset values, passthrough of the user controls
    check_outputs();
    for (k = 'h080; k <= 'h084; k++) begin
      check_read(xcvr_csr_pkg::csr_addr_t'(k));
    end
    check_read(xcvr_csr_pkg::ADDR_PRBS_CTRL);

    // holes in the map read zero
    foreach (unmapped[i]) begin
      check_read(unmapped[i]);
    end

    // random register contents against random user controls
    repeat (8) begin
      @(negedge avmm_clk);
      r32            = $random(seed);
      cur_in.chan_in = r32[6:0];
      cur_in.done    = r32[7];
      for (k = 0; k < 5; k++) begin
        r32 = $random(seed);
        bus_write(wr_addrs[k], r32[7:0]);
        check_outputs();
        check_read(wr_addrs[k]);
      end
    end

    // status through the synchronizers
    repeat (4) begin
      @(negedge avmm_clk);
      r32 = $random(seed);
      {cur_in.ltr, cur_in.ltd, cur_in.tx_busy, cur_in.rx_busy, cur_in.avmm_busy} = r32[4:0];
      poll_status(xcvr_csr_pkg::ADDR_GP_RD_LTR);
      poll_status(xcvr_csr_pkg::ADDR_GP_CAL_BUSY);
    end

    // counters held stable, fourteen bytes
    @(negedge avmm_clk);
    r64         = {$random(seed), $random(seed)};
    cur_in.err  = r64[49:0];
    r64         = {$random(seed), $random(seed)};
    cur_in.bits = r64[49:0];
    for (k = 'h101; k <= 'h10e; k++) begin
      check_read(xcvr_csr_pkg::csr_addr_t'(k));
    end

    // all three accumulator controls on, then off
    bus_write(xcvr_csr_pkg::ADDR_PRBS_CTRL, 8'h07);
    check_outputs();
    bus_write(xcvr_csr_pkg::ADDR_PRBS_CTRL, 8'h00);
    check_outputs();

    // one cycle error clear, must reach prbs_reset
    @(negedge avmm_clk);
    cur_in.err_clr = 1'b1;
    @(negedge avmm_clk);
    cur_in.err_clr = 1'b0;
    seen  = 1'b0;
    guard = 0;
    while (!seen && guard < POLL_LIMIT) begin
      #1;
      seen = prbs_reset;
      guard++;
      if (!seen) begin
        @(negedge avmm_clk);
      end
    end
    if (!seen) begin
      fail_plain("prbs_reset never rose after the error clear pulse");
    end
    repeat (4) @(negedge avmm_clk);
    check_outputs();

    // let the compare process empty its queue
    guard = 0;
    while (act_q.size() > 0 && guard < 4) begin
      @(negedge avmm_clk);
      guard++;
    end
    if (act_q.size() > 0) begin
      fail_plain("pending comparisons were never processed");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/xcvr_csr_pkg.sv
rtl/xcvr_csr_bus_ctrl.sv
rtl/xcvr_status_sync.sv
rtl/xcvr_chan_override.sv
rtl/xcvr_prbs_ctrl.sv
rtl/xcvr_debug_csr.sv
tb/xcvr_debug_csr_assert.sv
tb/xcvr_debug_csr_tb.sv
